//--- source/wb_pkg.sv
// Wishbone bus widths, address map and decoder target type
// Shared by the bus fabric, every slave and the testbench model
package wb_pkg;

    localparam int WB_AW = 32;
    localparam int WB_DW = 32;
    localparam int WB_SW = 4;   // Byte selects

    // Upper 16 address bits pick a region
    localparam logic [WB_AW-1:0] SRAM_BASE   = 32'h3000_0000;
    localparam logic [WB_AW-1:0] GPIO_BASE   = 32'h3001_0000;
    localparam logic [WB_AW-1:0] TEAM_BASE   = 32'h3002_0000;
    localparam logic [WB_AW-1:0] TEAM_STRIDE = 32'h0001_0000; // One region per team

    typedef enum logic [1:0] {
        TGT_SRAM,
        TGT_GPIO,
        TGT_TEAM,
        TGT_NONE
    } wb_target_e;

    // Read data of the unmapped responder
    localparam logic [WB_DW-1:0] UNMAPPED_DATA = '0;

endpackage

//--- source/pad_pkg.sv
// Pad count and layout of the per-pad team select fields
package pad_pkg;

    localparam int NUM_PADS      = 38;
    localparam int PAD_SEL_W     = 4;   // 0 is no driver, k is team k-1
    localparam int PADS_PER_WORD = 8;
    localparam int PAD_SEL_WORDS = 5;   // Covers 40 fields, top two unused

endpackage

//--- source/wb_arbiter.sv
// Two-manager Wishbone arbiter with a registered round-robin grant
// Host and aux requests are muxed onto one bus by the grant
module wb_arbiter import wb_pkg::*; (
    input  logic             wb_clk_i,
    input  logic             rst_n_i,
    input  logic             host_cyc_i,
    input  logic             host_stb_i,
    input  logic             host_we_i,
    input  logic [WB_SW-1:0] host_sel_i,
    input  logic [WB_AW-1:0] host_adr_i,
    input  logic [WB_DW-1:0] host_dat_i,
    output logic             host_ack_o,
    output logic [WB_DW-1:0] host_dat_o,
    input  logic             aux_cyc_i,
    input  logic             aux_stb_i,
    input  logic             aux_we_i,
    input  logic [WB_SW-1:0] aux_sel_i,
    input  logic [WB_AW-1:0] aux_adr_i,
    input  logic [WB_DW-1:0] aux_dat_i,
    output logic             aux_ack_o,
    output logic [WB_DW-1:0] aux_dat_o,
    output logic             m_cyc_o,
    output logic             m_stb_o,
    output logic             m_we_o,
    output logic [WB_SW-1:0] m_sel_o,
    output logic [WB_AW-1:0] m_adr_o,
    output logic [WB_DW-1:0] m_dat_o,
    input  logic             m_ack_i,
    input  logic [WB_DW-1:0] m_dat_i
);
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_HOST,
        ARB_AUX
    } arb_state_e;

    arb_state_e state_q, state_d;
    logic       aux_sel;

    // Grant moves only once the owner has dropped cyc
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (host_cyc_i) begin
                    state_d = ARB_HOST;
                end else if (aux_cyc_i) begin
                    state_d = ARB_AUX;
                end
            end
            ARB_HOST: if (!host_cyc_i) state_d = aux_cyc_i ? ARB_AUX : ARB_IDLE;
            ARB_AUX:  if (!aux_cyc_i) state_d = host_cyc_i ? ARB_HOST : ARB_IDLE;
            default:  state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            state_q <= ARB_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign aux_sel = (state_q == ARB_AUX);

    // Nothing reaches the bus while idle
    assign m_cyc_o = aux_sel ? aux_cyc_i : (state_q == ARB_HOST) && host_cyc_i;
    assign m_stb_o = aux_sel ? aux_stb_i : (state_q == ARB_HOST) && host_stb_i;
    assign m_we_o  = aux_sel ? aux_we_i  : host_we_i;
    assign m_sel_o = aux_sel ? aux_sel_i : host_sel_i;
    assign m_adr_o = aux_sel ? aux_adr_i : host_adr_i;
    assign m_dat_o = aux_sel ? aux_dat_i : host_dat_i;

    assign host_ack_o = (state_q == ARB_HOST) && m_ack_i;
    assign host_dat_o = (state_q == ARB_HOST) ? m_dat_i : '0;
    assign aux_ack_o  = aux_sel && m_ack_i;
    assign aux_dat_o  = aux_sel ? m_dat_i : '0;

endmodule

//--- source/wb_decoder.sv
// Address decoder: routes strobes to one peripheral and muxes its reply
// Index 0 is SRAM, 1 is GPIO control, 2 upward are the teams
module wb_decoder import wb_pkg::*; #(
    parameter int NUM_TEAMS = 2
) (
    input  logic                            wb_clk_i,
    input  logic                            rst_n_i,
    input  logic                            m_cyc_i,
    input  logic                            m_stb_i,
    input  logic                            m_we_i,
    input  logic [WB_SW-1:0]                m_sel_i,
    input  logic [WB_AW-1:0]                m_adr_i,
    input  logic [WB_DW-1:0]                m_dat_i,
    output logic                            m_ack_o,
    output logic [WB_DW-1:0]                m_dat_o,
    output logic [NUM_TEAMS+1:0]            p_cyc_o,
    output logic [NUM_TEAMS+1:0]            p_stb_o,
    output logic                            p_we_o,
    output logic [WB_SW-1:0]                p_sel_o,
    output logic [WB_AW-1:0]                p_adr_o,
    output logic [WB_DW-1:0]                p_dat_o,
    input  logic [NUM_TEAMS+1:0]            p_ack_i,
    input  logic [NUM_TEAMS+1:0][WB_DW-1:0] p_dat_i
);
    localparam int PW = $clog2(NUM_TEAMS + 2);

    wb_target_e       tgt_d, tgt_q;
    logic [PW-1:0]    pidx_d, pidx_q;
    logic [WB_AW-1:0] team_off;
    logic             req;
    logic             none_ack_q;

    assign req      = m_cyc_i && m_stb_i;
    assign team_off = (m_adr_i - TEAM_BASE) >> $clog2(TEAM_STRIDE);

    always_comb begin
        tgt_d  = TGT_NONE;
        pidx_d = '0;
        if (m_adr_i[WB_AW-1:16] == SRAM_BASE[WB_AW-1:16]) begin
            tgt_d = TGT_SRAM;
        end else if (m_adr_i[WB_AW-1:16] == GPIO_BASE[WB_AW-1:16]) begin
            tgt_d  = TGT_GPIO;
            pidx_d = PW'(1);
        end else if (m_adr_i >= TEAM_BASE && team_off < NUM_TEAMS) begin
            tgt_d  = TGT_TEAM;
            pidx_d = PW'(team_off + 2);
        end
    end

    always_comb begin
        p_cyc_o = '0;
        p_stb_o = '0;
        if (tgt_d != TGT_NONE) begin
            p_cyc_o[pidx_d] = m_cyc_i;
            p_stb_o[pidx_d] = req;
        end
    end

    assign p_we_o  = m_we_i;
    assign p_sel_o = m_sel_i;
    assign p_adr_o = m_adr_i;
    assign p_dat_o = m_dat_i;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            tgt_q      <= TGT_NONE;
            pidx_q     <= '0;
            none_ack_q <= 1'b0;
        end else begin
            none_ack_q <= req && (tgt_d == TGT_NONE) && !none_ack_q; // Writes dropped
            if (req) begin
                tgt_q  <= tgt_d;
                pidx_q <= pidx_d;
            end
        end
    end

    assign m_ack_o = (tgt_q == TGT_NONE) ? none_ack_q : p_ack_i[pidx_q];
    assign m_dat_o = (tgt_q == TGT_NONE) ? UNMAPPED_DATA : p_dat_i[pidx_q];

endmodule

//--- source/wb_sram.sv
// Word SRAM behind a Wishbone slave, byte writes through sel
// Aliases inside its region, read data registered with the ack
module wb_sram import wb_pkg::*; #(
    parameter int SRAM_AW = 8
) (
    input  logic             wb_clk_i,
    input  logic             rst_n_i,
    input  logic             wbs_cyc_i,
    input  logic             wbs_stb_i,
    input  logic             wbs_we_i,
    input  logic [WB_SW-1:0] wbs_sel_i,
    input  logic [WB_AW-1:0] wbs_adr_i,
    input  logic [WB_DW-1:0] wbs_dat_i,
    output logic             wbs_ack_o,
    output logic [WB_DW-1:0] wbs_dat_o
);
    logic [WB_DW-1:0]   mem [2**SRAM_AW];
    logic [SRAM_AW-1:0] widx;
    logic               access;

    assign widx   = wbs_adr_i[SRAM_AW+1:2];
    assign access = wbs_cyc_i && wbs_stb_i && !wbs_ack_o; // One ack per strobe

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            wbs_ack_o <= 1'b0;
        end else begin
            wbs_ack_o <= access;
        end
    end

    always_ff @(posedge wb_clk_i) begin
        if (access) begin
            wbs_dat_o <= mem[widx];
            if (wbs_we_i) begin
                for (int b = 0; b < WB_SW; b++) begin
                    if (wbs_sel_i[b]) mem[widx][8*b +: 8] <= wbs_dat_i[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- source/gpio_ctrl_regs.sv
// Pad select registers, eight 4-bit team fields per word
// Drives the pad mux directly, so a write shows on the pads at its ack
module gpio_ctrl_regs import wb_pkg::*, pad_pkg::*; (
    input  logic                                wb_clk_i,
    input  logic                                rst_n_i,
    input  logic                                wbs_cyc_i,
    input  logic                                wbs_stb_i,
    input  logic                                wbs_we_i,
    input  logic [WB_SW-1:0]                    wbs_sel_i,
    input  logic [WB_AW-1:0]                    wbs_adr_i,
    input  logic [WB_DW-1:0]                    wbs_dat_i,
    output logic                                wbs_ack_o,
    output logic [WB_DW-1:0]                    wbs_dat_o,
    output logic [NUM_PADS-1:0][PAD_SEL_W-1:0]  pad_sel_o
);
    localparam int WIDX_W = $clog2(PAD_SEL_WORDS);

    logic [PAD_SEL_WORDS-1:0][PADS_PER_WORD-1:0][PAD_SEL_W-1:0] words_q;
    logic [WIDX_W-1:0] widx;
    logic              in_range;
    logic              access;

    assign widx     = wbs_adr_i[WIDX_W+1:2];
    assign in_range = int'(widx) < PAD_SEL_WORDS;
    assign access   = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            words_q   <= '0;
            wbs_ack_o <= 1'b0;
            wbs_dat_o <= '0;
        end else begin
            wbs_ack_o <= access;
            if (access) begin
                wbs_dat_o <= in_range ? WB_DW'(words_q[widx]) : '0;
                if (wbs_we_i && in_range) begin
                    for (int k = 0; k < PADS_PER_WORD; k++) begin
                        // Fields past the last pad stay 0
                        if (int'(widx) * PADS_PER_WORD + k < NUM_PADS &&
                            wbs_sel_i[k*PAD_SEL_W/8]) begin
                            words_q[widx][k] <= wbs_dat_i[k*PAD_SEL_W +: PAD_SEL_W];
                        end
                    end
                end
            end
        end
    end

    // Pad 0 sits in the low field of word 0
    assign pad_sel_o = (NUM_PADS*PAD_SEL_W)'(words_q);

endmodule

//--- source/gpio_mux.sv
// Per-pad pick of one team's out and oeb by the select fields
// Unselected or out-of-range pads are driven low with output disabled
module gpio_mux import pad_pkg::*; #(
    parameter int NUM_TEAMS = 2
) (
    input  logic [NUM_PADS-1:0][PAD_SEL_W-1:0]  pad_sel_i,
    input  logic [NUM_TEAMS-1:0][NUM_PADS-1:0]  team_out_i,
    input  logic [NUM_TEAMS-1:0][NUM_PADS-1:0]  team_oeb_i,
    output logic [NUM_PADS-1:0]                 io_out_o,
    output logic [NUM_PADS-1:0]                 io_oeb_o
);
    int unsigned sel;

    always_comb begin
        io_out_o = '0;
        io_oeb_o = '1;  // Active low enable
        for (int p = 0; p < NUM_PADS; p++) begin
            sel = pad_sel_i[p];
            if (sel != 0 && sel <= NUM_TEAMS) begin
                io_out_o[p] = team_out_i[sel-1][p];
                io_oeb_o[p] = team_oeb_i[sel-1][p];
            end
        end
    end

endmodule

//--- source/team_pwm.sv
// Team design: PWM generator with period, duty and enable registers
// The PWM bit goes to every pad, oeb follows the inverted enable
module team_pwm import wb_pkg::*, pad_pkg::*; (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    input  logic                wbs_cyc_i,
    input  logic                wbs_stb_i,
    input  logic                wbs_we_i,
    input  logic [WB_SW-1:0]    wbs_sel_i,
    input  logic [WB_AW-1:0]    wbs_adr_i,
    input  logic [WB_DW-1:0]    wbs_dat_i,
    output logic                wbs_ack_o,
    output logic [WB_DW-1:0]    wbs_dat_o,
    output logic [NUM_PADS-1:0] gpio_out_o,
    output logic [NUM_PADS-1:0] gpio_oeb_o
);
    logic [15:0] period_q, duty_q, cnt_q;
    logic        en_q;
    logic        pwm_q;
    logic        access;

    assign access = wbs_cyc_i && wbs_stb_i && !wbs_ack_o;

    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            period_q  <= '0;
            duty_q    <= '0;
            en_q      <= 1'b0;
            wbs_ack_o <= 1'b0;
            wbs_dat_o <= '0;
        end else begin
            wbs_ack_o <= access;
            if (access) begin
                case (wbs_adr_i[3:2])
                    2'd0:    wbs_dat_o <= {16'b0, period_q};
                    2'd1:    wbs_dat_o <= {16'b0, duty_q};
                    2'd2:    wbs_dat_o <= {31'b0, en_q};
                    default: wbs_dat_o <= '0;
                endcase
                if (wbs_we_i) begin
                    for (int b = 0; b < 2; b++) begin
                        if (wbs_sel_i[b] && wbs_adr_i[3:2] == 2'd0) begin
                            period_q[8*b +: 8] <= wbs_dat_i[8*b +: 8];
                        end
                        if (wbs_sel_i[b] && wbs_adr_i[3:2] == 2'd1) begin
                            duty_q[8*b +: 8] <= wbs_dat_i[8*b +: 8];
                        end
                    end
                    if (wbs_sel_i[0] && wbs_adr_i[3:2] == 2'd2) en_q <= wbs_dat_i[0];
                end
            end
        end
    end

    // Counter held at 0 while disabled
    always_ff @(posedge wb_clk_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
            pwm_q <= 1'b0;
        end else begin
            cnt_q <= (!en_q || cnt_q >= period_q) ? 16'd0 : cnt_q + 16'd1;
            pwm_q <= cnt_q < duty_q;
        end
    end

    assign gpio_out_o = {NUM_PADS{pwm_q}};
    assign gpio_oeb_o = {NUM_PADS{!en_q}};

endmodule

//--- source/nebula_top.sv
// Shared chip top: two managers, one Wishbone bus, SRAM, pad control
// and NUM_TEAMS PWM team designs muxed onto the 38 pads
module nebula_top import wb_pkg::*, pad_pkg::*; #(
    parameter int NUM_TEAMS = 2,
    parameter int SRAM_AW   = 8
) (
    input  logic                wb_clk_i,
    input  logic                rst_n_i,
    // Host port from the management controller
    input  logic                wbs_cyc_i,
    input  logic                wbs_stb_i,
    input  logic                wbs_we_i,
    input  logic [WB_SW-1:0]    wbs_sel_i,
    input  logic [WB_AW-1:0]    wbs_adr_i,
    input  logic [WB_DW-1:0]    wbs_dat_i,
    output logic                wbs_ack_o,
    output logic [WB_DW-1:0]    wbs_dat_o,
    // Auxiliary manager, stands in for the CPU
    input  logic                aux_cyc_i,
    input  logic                aux_stb_i,
    input  logic                aux_we_i,
    input  logic [WB_SW-1:0]    aux_sel_i,
    input  logic [WB_AW-1:0]    aux_adr_i,
    input  logic [WB_DW-1:0]    aux_dat_i,
    output logic                aux_ack_o,
    output logic [WB_DW-1:0]    aux_dat_o,
    output logic [NUM_PADS-1:0] io_out_o,
    output logic [NUM_PADS-1:0] io_oeb_o
);
    localparam int NP = NUM_TEAMS + 2;

    logic             m_cyc, m_stb, m_we, m_ack;
    logic [WB_SW-1:0] m_sel;
    logic [WB_AW-1:0] m_adr;
    logic [WB_DW-1:0] m_wdat, m_rdat;

    logic [NP-1:0]            p_cyc, p_stb, p_ack;
    logic                     p_we;
    logic [WB_SW-1:0]         p_sel;
    logic [WB_AW-1:0]         p_adr;
    logic [WB_DW-1:0]         p_wdat;
    logic [NP-1:0][WB_DW-1:0] p_rdat;

    logic [NUM_PADS-1:0][PAD_SEL_W-1:0] pad_sel;
    logic [NUM_TEAMS-1:0][NUM_PADS-1:0] team_out, team_oeb;

    wb_arbiter u_arbiter (
        .wb_clk_i, .rst_n_i,
        .host_cyc_i(wbs_cyc_i), .host_stb_i(wbs_stb_i), .host_we_i(wbs_we_i),
        .host_sel_i(wbs_sel_i), .host_adr_i(wbs_adr_i), .host_dat_i(wbs_dat_i),
        .host_ack_o(wbs_ack_o), .host_dat_o(wbs_dat_o),
        .aux_cyc_i, .aux_stb_i, .aux_we_i, .aux_sel_i, .aux_adr_i, .aux_dat_i,
        .aux_ack_o, .aux_dat_o,
        .m_cyc_o(m_cyc), .m_stb_o(m_stb), .m_we_o(m_we), .m_sel_o(m_sel),
        .m_adr_o(m_adr), .m_dat_o(m_wdat), .m_ack_i(m_ack), .m_dat_i(m_rdat)
    );

    wb_decoder #(.NUM_TEAMS(NUM_TEAMS)) u_decoder (
        .wb_clk_i, .rst_n_i,
        .m_cyc_i(m_cyc), .m_stb_i(m_stb), .m_we_i(m_we), .m_sel_i(m_sel),
        .m_adr_i(m_adr), .m_dat_i(m_wdat), .m_ack_o(m_ack), .m_dat_o(m_rdat),
        .p_cyc_o(p_cyc), .p_stb_o(p_stb), .p_we_o(p_we), .p_sel_o(p_sel),
        .p_adr_o(p_adr), .p_dat_o(p_wdat), .p_ack_i(p_ack), .p_dat_i(p_rdat)
    );

    wb_sram #(.SRAM_AW(SRAM_AW)) u_sram (
        .wb_clk_i, .rst_n_i,
        .wbs_cyc_i(p_cyc[0]), .wbs_stb_i(p_stb[0]), .wbs_we_i(p_we), .wbs_sel_i(p_sel),
        .wbs_adr_i(p_adr), .wbs_dat_i(p_wdat), .wbs_ack_o(p_ack[0]), .wbs_dat_o(p_rdat[0])
    );

    gpio_ctrl_regs u_gpio_regs (
        .wb_clk_i, .rst_n_i,
        .wbs_cyc_i(p_cyc[1]), .wbs_stb_i(p_stb[1]), .wbs_we_i(p_we), .wbs_sel_i(p_sel),
        .wbs_adr_i(p_adr), .wbs_dat_i(p_wdat), .wbs_ack_o(p_ack[1]), .wbs_dat_o(p_rdat[1]),
        .pad_sel_o(pad_sel)
    );

    for (genvar t = 0; t < NUM_TEAMS; t++) begin : g_team
        team_pwm u_team (
            .wb_clk_i, .rst_n_i,
            .wbs_cyc_i(p_cyc[t+2]), .wbs_stb_i(p_stb[t+2]), .wbs_we_i(p_we),
            .wbs_sel_i(p_sel), .wbs_adr_i(p_adr), .wbs_dat_i(p_wdat),
            .wbs_ack_o(p_ack[t+2]), .wbs_dat_o(p_rdat[t+2]),
            .gpio_out_o(team_out[t]), .gpio_oeb_o(team_oeb[t])
        );
    end

    gpio_mux #(.NUM_TEAMS(NUM_TEAMS)) u_gpio_mux (
        .pad_sel_i(pad_sel), .team_out_i(team_out), .team_oeb_i(team_oeb),
        .io_out_o, .io_oeb_o
    );

endmodule

//--- tests/nebula_props.sv
// Concurrent checks on manager acks and pad enables
// Bound into the chip top, reports through failing assertions only
module nebula_props import pad_pkg::*; (
    input logic                               clk_i,
    input logic                               rst_n_i,
    input logic                               host_stb_i,
    input logic                               host_ack_i,
    input logic                               aux_stb_i,
    input logic                               aux_ack_i,
    input logic [NUM_PADS-1:0][PAD_SEL_W-1:0] pad_sel_i,
    input logic [NUM_PADS-1:0]                io_oeb_i
);
    logic [NUM_PADS-1:0] sel_zero;

    always_comb begin
        for (int p = 0; p < NUM_PADS; p++) begin
            sel_zero[p] = (pad_sel_i[p] == '0);
        end
    end

    ack_one_manager: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(host_ack_i && aux_ack_i)) else $error("host and aux ack high together");

    host_ack_in_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        host_ack_i |-> host_stb_i) else $error("host ack without host strobe");

    aux_ack_in_stb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        aux_ack_i |-> aux_stb_i) else $error("aux ack without aux strobe");

    // Undriven pads keep the output disabled
    unsel_pad_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        &(io_oeb_i | ~sel_zero)) else $error("pad with select 0 has output enabled");

    reset_pads_off: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> &io_oeb_i) else $error("pad output enabled right after reset");

endmodule

bind nebula_top nebula_props u_props (
    .clk_i(wb_clk_i), .rst_n_i(rst_n_i),
    .host_stb_i(wbs_stb_i), .host_ack_i(wbs_ack_o),
    .aux_stb_i(aux_stb_i), .aux_ack_i(aux_ack_o),
    .pad_sel_i(pad_sel), .io_oeb_i(io_oeb_o)
);

//--- tests/nebula_tb.sv
// Testbench for the shared bus top: random host and aux traffic checked against a model
// Covers SRAM, pad select registers, team PWM pads and unmapped regions
module nebula_tb import wb_pkg::*, pad_pkg::*; ();
    localparam int NUM_TEAMS   = 2;
    localparam int SRAM_AW     = 8;
    localparam int SRAM_WORDS  = 2**SRAM_AW;
    localparam int SEED        = 43224;
    localparam int N_SRAM      = 64;    // Masked writes, then as many reads
    localparam int N_PAR       = 80;    // Per manager
    localparam int N_SEL       = 12;
    localparam int N_ROUNDS    = 4;
    localparam int DRV_DLY     = 1;
    localparam int ACK_TIMEOUT = 40;
    localparam int OP_COUNT    = 3 * (8 + 3 * NUM_TEAMS) + SRAM_WORDS + 2 * N_SRAM
                               + 2 * N_PAR + N_SEL + N_ROUNDS * (3 * NUM_TEAMS + 5) + 8;

    // Index 0 is the host port, 1 the aux manager
    logic                       clk;
    logic                       rst_n;
    logic [1:0]                 cyc, stb, we, ack;
    logic [1:0][WB_SW-1:0]      sel;
    logic [1:0][WB_AW-1:0]      adr;
    logic [1:0][WB_DW-1:0]      wdat, rdat;
    logic [NUM_PADS-1:0]        io_out, io_oeb;

    // Reference model
    logic [WB_DW-1:0] sram_m [SRAM_WORDS];
    logic [WB_DW-1:0] gpio_m [8];   // Words 5 to 7 stay 0
    logic [15:0]      period_m [NUM_TEAMS];
    logic [15:0]      duty_m [NUM_TEAMS];
    logic             en_m [NUM_TEAMS];

    nebula_top #(.NUM_TEAMS(NUM_TEAMS), .SRAM_AW(SRAM_AW)) DUT (
        .wb_clk_i(clk), .rst_n_i(rst_n),
        .wbs_cyc_i(cyc[0]), .wbs_stb_i(stb[0]), .wbs_we_i(we[0]), .wbs_sel_i(sel[0]),
        .wbs_adr_i(adr[0]), .wbs_dat_i(wdat[0]), .wbs_ack_o(ack[0]), .wbs_dat_o(rdat[0]),
        .aux_cyc_i(cyc[1]), .aux_stb_i(stb[1]), .aux_we_i(we[1]), .aux_sel_i(sel[1]),
        .aux_adr_i(adr[1]), .aux_dat_i(wdat[1]), .aux_ack_o(ack[1]), .aux_dat_o(rdat[1]),
        .io_out_o(io_out), .io_oeb_o(io_oeb)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic model_write(input logic [WB_AW-1:0] a, input logic [WB_DW-1:0] d,
                               input logic [WB_SW-1:0] s);
        int t;
        int w;
        t = int'(a[31:16]) - int'(TEAM_BASE[31:16]);
        w = int'(a[4:2]);
        if (a[31:16] == SRAM_BASE[31:16]) begin
            for (int b = 0; b < WB_SW; b++) begin
                if (s[b]) sram_m[a[SRAM_AW+1:2]][8*b +: 8] = d[8*b +: 8];
            end
        end else if (a[31:16] == GPIO_BASE[31:16]) begin
            for (int k = 0; k < PADS_PER_WORD; k++) begin
                // Nibble k sits in byte k/2, no field past pad 37
                if (w < PAD_SEL_WORDS && w * PADS_PER_WORD + k < NUM_PADS && s[k/2])
                    gpio_m[w][4*k +: 4] = d[4*k +: 4];
            end
        end else if (t >= 0 && t < NUM_TEAMS) begin
            for (int b = 0; b < 2; b++) begin
                if (s[b] && a[3:2] == 2'd0) period_m[t][8*b +: 8] = d[8*b +: 8];
                if (s[b] && a[3:2] == 2'd1) duty_m[t][8*b +: 8] = d[8*b +: 8];
            end
            if (s[0] && a[3:2] == 2'd2) en_m[t] = d[0];
        end
    endtask

    function automatic logic [WB_DW-1:0] model_read(input logic [WB_AW-1:0] a);
        int t;
        t = int'(a[31:16]) - int'(TEAM_BASE[31:16]);
        if (a[31:16] == SRAM_BASE[31:16]) return sram_m[a[SRAM_AW+1:2]];
        if (a[31:16] == GPIO_BASE[31:16]) return gpio_m[a[4:2]];
        if (t >= 0 && t < NUM_TEAMS) begin
            case (a[3:2])
                2'd0:    return {16'b0, period_m[t]};
                2'd1:    return {16'b0, duty_m[t]};
                2'd2:    return {31'b0, en_m[t]};
                default: return '0;
            endcase
        end
        return UNMAPPED_DATA;
    endfunction

    // One Wishbone classic access, held until ack is seen at a rising edge
    task automatic bus_access(input int m, input logic w, input logic [WB_AW-1:0] a,
                              input logic [WB_DW-1:0] d, input logic [WB_SW-1:0] s,
                              output logic [WB_DW-1:0] q);
        int waited;
        waited = 0;
        @(posedge clk);
        #DRV_DLY;
        cyc[m]  = 1'b1;
        stb[m]  = 1'b1;
        we[m]   = w;
        adr[m]  = a;
        wdat[m] = d;
        sel[m]  = s;
        do begin
            @(negedge clk);
            waited++;
            if (waited > ACK_TIMEOUT)
                abort_run($sformatf("no ack within %0d cycles for address %h", ACK_TIMEOUT, a));
        end while (!ack[m]);
        q = rdat[m];
        @(posedge clk);
        #DRV_DLY;
        cyc[m] = 1'b0;
        stb[m] = 1'b0;
    endtask

    task automatic do_write(input int m, input logic [WB_AW-1:0] a, input logic [WB_DW-1:0] d,
                            input logic [WB_SW-1:0] s);
        logic [WB_DW-1:0] discard;
        bus_access(m, 1'b1, a, d, s, discard);
        model_write(a, d, s);
    endtask

    task automatic do_read(input int m, input logic [WB_AW-1:0] a);
        logic [WB_DW-1:0] got;
        bus_access(m, 1'b0, a, '0, '1, got);
        check_eq(m != 0 ? "aux_dat_o" : "wbs_dat_o", got, model_read(a));
    endtask

    function automatic logic [WB_AW-1:0] sram_adr(input int lo, input int hi);
        return SRAM_BASE + WB_AW'(4 * $urandom_range(hi, lo));
    endfunction

    function automatic logic [WB_DW-1:0] rand_sel_word();
        logic [WB_DW-1:0] v;
        for (int k = 0; k < PADS_PER_WORD; k++) v[4*k +: 4] = 4'($urandom_range(NUM_TEAMS + 1, 0));
        return v;
    endfunction

    // Pads settle two cycles after the last ack
    task automatic check_pads();
        logic [NUM_PADS-1:0] exp_out, exp_oeb;
        int s;
        for (int p = 0; p < NUM_PADS; p++) begin
            s = int'(gpio_m[p / PADS_PER_WORD][PAD_SEL_W * (p % PADS_PER_WORD) +: PAD_SEL_W]);
            exp_out[p] = 1'b0;
            exp_oeb[p] = 1'b1;
            if (s >= 1 && s <= NUM_TEAMS) begin
                exp_out[p] = duty_m[s-1] > period_m[s-1];  // Duty is 0 or past period
                exp_oeb[p] = !en_m[s-1];
            end
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_eq("io_out_o", 64'(io_out), 64'(exp_out));
        check_eq("io_oeb_o", 64'(io_oeb), 64'(exp_oeb));
    endtask

    task automatic check_state();
        for (int w = 0; w < 8; w++) do_read(0, GPIO_BASE + WB_AW'(4 * w));
        for (int t = 0; t < NUM_TEAMS; t++) begin
            for (int r = 0; r < 3; r++) do_read(0, TEAM_BASE + TEAM_STRIDE * t + WB_AW'(4 * r));
        end
        check_pads();
    endtask

    // Each manager owns half the SRAM and its own select words
    task automatic random_traffic(input int m);
        logic [WB_AW-1:0] a;
        for (int i = 0; i < N_PAR; i++) begin
            if ($urandom_range(3, 0) == 0)
                a = GPIO_BASE + WB_AW'(4 * (m != 0 ? $urandom_range(4, 3) : $urandom_range(2, 0)));
            else
                a = sram_adr(m * SRAM_WORDS / 2, (m + 1) * SRAM_WORDS / 2 - 1);
            if ($urandom_range(1, 0) != 0) do_write(m, a, $urandom, 4'($urandom));
            else do_read(m, a);
        end
    endtask

    initial begin
        logic [15:0]      period;
        logic [WB_AW-1:0] base;
        logic [WB_AW-1:0] unmapped [4];
        void'($urandom(SEED));
        cyc   = '0;
        stb   = '0;
        we    = '0;
        sel   = '0;
        adr   = '0;
        wdat  = '0;
        rst_n = 1'b0;
        for (int w = 0; w < 8; w++) gpio_m[w] = '0;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            period_m[t] = '0;
            duty_m[t]   = '0;
            en_m[t]     = 1'b0;
        end
        repeat (3) @(posedge clk);
        #DRV_DLY;
        rst_n = 1'b1;

        check_state();  // Reset values

        for (int i = 0; i < SRAM_WORDS; i++) do_write(0, SRAM_BASE + WB_AW'(4 * i), $urandom, '1);
        for (int i = 0; i < N_SRAM; i++)
            do_write(0, sram_adr(0, SRAM_WORDS - 1), $urandom, 4'($urandom));
        for (int i = 0; i < N_SRAM; i++) do_read(0, sram_adr(0, SRAM_WORDS - 1));

        fork
            random_traffic(0);
            random_traffic(1);
        join

        for (int i = 0; i < N_SEL; i++)
            do_write(0, GPIO_BASE + WB_AW'(4 * $urandom_range(7, 0)), $urandom, 4'($urandom));
        check_state();

        for (int r = 0; r < N_ROUNDS; r++) begin
            for (int t = 0; t < NUM_TEAMS; t++) begin
                period = 16'($urandom_range(1000, 0));
                base   = TEAM_BASE + TEAM_STRIDE * t;
                do_write(r % 2, base, 32'(period), '1);
                do_write(r % 2, base + 4, $urandom_range(1, 0) != 0 ? 32'd0 :
                         32'(period) + 1 + $urandom_range(200, 0), '1);
                do_write(r % 2, base + 8, $urandom_range(1, 0), '1);
            end
            for (int w = 0; w < PAD_SEL_WORDS; w++)
                do_write(0, GPIO_BASE + WB_AW'(4 * w), rand_sel_word(), '1);
            check_pads();
        end

        unmapped[0] = TEAM_BASE + TEAM_STRIDE * NUM_TEAMS;  // First team index past the last
        unmapped[1] = 32'h0000_0100;
        unmapped[2] = 32'h2fff_fffc;
        unmapped[3] = 32'h7fff_0008;
        for (int i = 0; i < 4; i++) begin
            do_write(1, unmapped[i], $urandom, '1);
            do_read(1, unmapped[i]);
        end
        check_state();

        $display(">>> PASS");
        $finish;
    end

    // Budget of 20 cycles per bus operation
    initial begin
        repeat (OP_COUNT * 20) @(posedge clk);
        abort_run("watchdog expired before all tests finished");
    end

endmodule

//--- src.f
source/wb_pkg.sv
source/pad_pkg.sv
source/wb_arbiter.sv
source/wb_decoder.sv
source/wb_sram.sv
source/gpio_ctrl_regs.sv
source/gpio_mux.sv
source/team_pwm.sv
source/nebula_top.sv
tests/nebula_props.sv
tests/nebula_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := nebula_tb
RTL_TOP    := nebula_top
FILELIST   := src.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
